//--- rvc_trace.txt
# W fp_en                      config write
# T instr valid exp_instr exp_illegal exp_compressed   all hex
T 00500093 1 00500093 0 0
T 002081b3 1 002081b3 0 0
T 00000505 0 00150513 0 1
T 00000505 1 00150513 0 1
T 000055fd 1 fff00593 0 1
T 00006285 1 000012b7 0 1
T 00006141 1 01010113 0 1
T 00008c05 1 40940433 0 1
T 00008d6d 1 00b57533 0 1
T 0000860d 1 40365613 0 1
T 0000a021 1 0080006f 0 1
T 00002021 1 008000ef 0 1
T 0000c011 1 00040263 0 1
T 0000fcfd 1 fe049fe3 0 1
T 00000040 1 00410413 0 1
T 00004144 1 00452483 0 1
T 0000c504 1 00952423 0 1
T 0000028a 1 00229293 0 1
T 00004322 1 00812303 0 1
T 0000c61e 1 00712623 0 1
T 00008082 1 00008067 0 1
T 0000852e 1 00b00533 0 1
T 0000952e 1 00b50533 0 1
T 00009002 1 00100073 0 1
T 00009282 1 000280e7 0 1
T 00000000 1 00000000 1 1
T 00006281 1 00006281 1 1
T 00004022 1 00004022 1 1
T 00008002 1 00008002 1 1
T 00009c05 1 00009c05 1 1
T 00009c25 1 00009c25 1 1
T abcd8000 1 abcd8000 1 1
T 00006144 1 00006144 1 1
T 0000e504 1 0000e504 1 1
T 00002504 1 00002504 1 1
T 0000a504 1 0000a504 1 1
T 00006322 1 00006322 1 1
W 1
T 00006144 1 00452487 0 1
T 0000e504 1 00952427 0 1
T 00002504 1 00853487 0 1
T 0000a504 1 00953427 0 1
T 00006322 1 00812307 0 1
T 00002322 1 00813307 0 1
W 0
T 00002322 1 00002322 1 1

//--- tb.f
rvc_pkg.sv
rvc_cfg_regs.sv
rvc_q0_dec.sv
rvc_q1_dec.sv
rvc_q2_dec.sv
rvc_expander.sv
rvc_decoder_top.sv
tb_clk_gen.sv
tb_rvc_asserts.sv
tb_rvc_decoder.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the expander testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rvc_decoder -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

//--- tb_rvc_decoder.sv
// ------------------------------------------------
// reads rvc_trace.txt from the run directory
// one trace line per cycle, results checked 2 edges later
// ------------------------------------------------
`timescale 1ns/1ps

module tb_rvc_decoder
    import rvc_pkg::*;
();

    logic      clk;
    logic      arst_n;
    rvc_word_t instr;
    logic      valid;
    logic      cfg_we;
    logic      cfg_fp_en;
    rvc_out_t  dut_out;
    string     lines[$];
    rvc_out_t  exp_q[$];
    int        cycle_cnt = 0;
    int        cycle_limit = 0;

    tb_clk_gen clk_gen0 (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rvc_decoder_top dut0 (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .instr_i     (instr),
        .valid_i     (valid),
        .cfg_we_i    (cfg_we),
        .cfg_fp_en_i (cfg_fp_en),
        .out_o       (dut_out)
    );

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_out(input rvc_out_t expected);
        check_field("out_o.instr", expected.instr, dut_out.instr);
        check_field("out_o.illegal", 32'(expected.illegal), 32'(dut_out.illegal));
        check_field("out_o.is_compressed", 32'(expected.is_compressed),
                    32'(dut_out.is_compressed));
        check_field("out_o.valid", 32'(expected.valid), 32'(dut_out.valid));
    endtask

    task automatic read_trace();
        int    fd;
        int    code;
        string line;
        fd = $fopen("rvc_trace.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the trace file rvc_trace.txt");
            $display("Result: FAILED");
            $fatal(1, "missing trace");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip blank lines and column notes
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    // quiet cycle, an uncompressed nop with valid low
    task automatic apply_idle();
        cfg_we <= 1'b0;
        instr  <= 32'h0000_0013;
        valid  <= 1'b0;
        exp_q.push_back('{instr: 32'h0000_0013, illegal: 1'b0, is_compressed: 1'b0,
                          valid: 1'b0});
    endtask

    task automatic apply_line(input string line);
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        int          n;
        string       fields;
        fields = line.substr(2, line.len() - 1);
        if (line.getc(0) == 8'h57) begin
            // W line: config write of fp_en
            n = $sscanf(fields, "%h", f0);
            assert (n == 1) else begin
                $display("malformed config line in trace: %s", line);
                $display("Result: FAILED");
                $fatal(1, "bad trace");
            end
            apply_idle();
            cfg_we    <= 1'b1;
            cfg_fp_en <= f0[0];
        end else begin
            n = $sscanf(fields, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            assert (n == 5) else begin
                $display("malformed transaction line in trace: %s", line);
                $display("Result: FAILED");
                $fatal(1, "bad trace");
            end
            cfg_we <= 1'b0;
            instr  <= f0;
            valid  <= f1[0];
            exp_q.push_back('{instr: f2, illegal: f3[0], is_compressed: f4[0],
                              valid: f1[0]});
        end
    endtask

    // ------------------------------------------------
    // main sequence
    // ------------------------------------------------
    initial begin
        instr     <= 32'h0000_0013;
        valid     <= 1'b0;
        cfg_we    <= 1'b0;
        cfg_fp_en <= 1'b0;
        read_trace();
        cycle_limit = lines.size() + 8 + 20;
        @(posedge arst_n);
        @(posedge clk);
        compare_out('0);
        foreach (lines[i]) begin
            if (exp_q.size() == 2) begin
                compare_out(exp_q.pop_front());
            end
            apply_line(lines[i]);
            @(posedge clk);
        end
        // drain the pipeline with idle cycles
        repeat (2) begin
            compare_out(exp_q.pop_front());
            apply_idle();
            @(posedge clk);
        end
        compare_out(exp_q.pop_front());
        $display("Result: PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- tb_rvc_asserts.sv
// ------------------------------------------------
// concurrent checks on the expander outputs
// ------------------------------------------------
`timescale 1ns/1ps

module tb_rvc_asserts
    import rvc_pkg::*;
(
    input logic     clk_i,
    input logic     arst_n_i,
    input logic     valid_i,
    input rvc_out_t out_o
);

    // only a compressed word can be reserved
    illegal_needs_compressed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_o.illegal |-> out_o.is_compressed)
        else $error("illegal flag set on an uncompressed word");

    zero_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> (out_o == '0))
        else $error("output bundle not cleared while in reset");

    // fixed one-cycle latency of the strobe
    valid_follows_input: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_o.valid == $past(valid_i))
        else $error("output valid does not follow input valid by one cycle");

endmodule

bind rvc_decoder_top tb_rvc_asserts asserts0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .out_o    (out_o)
);

//--- tb_clk_gen.sv
// ------------------------------------------------
// testbench clock, 20 ns period
// reset low for 8 cycles, released on a falling edge
// ------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

//--- rvc_decoder_top.sv
// ------------------------------------------------
// RV32C expander top, fixed 1-cycle latency
// no back-pressure, a word may arrive every cycle
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_decoder_top
    import rvc_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  rvc_word_t instr_i,
    input  logic      valid_i,
    input  logic      cfg_we_i,
    input  logic      cfg_fp_en_i,
    output rvc_out_t  out_o
);

    logic     fp_en;
    rvc_exp_t q0_exp;
    rvc_exp_t q1_exp;
    rvc_exp_t q2_exp;

    rvc_cfg_regs cfg0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_fp_en_i (cfg_fp_en_i),
        .fp_en_o     (fp_en)
    );

    // all three decoders look at the same halfword
    rvc_q0_dec q0_dec0 (
        .cinstr_i (instr_i[15:0]),
        .fp_en_i  (fp_en),
        .exp_o    (q0_exp)
    );

    rvc_q1_dec q1_dec0 (
        .cinstr_i (instr_i[15:0]),
        .exp_o    (q1_exp)
    );

    rvc_q2_dec q2_dec0 (
        .cinstr_i (instr_i[15:0]),
        .fp_en_i  (fp_en),
        .exp_o    (q2_exp)
    );

    rvc_expander exp0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .instr_i  (instr_i),
        .valid_i  (valid_i),
        .q0_i     (q0_exp),
        .q1_i     (q1_exp),
        .q2_i     (q2_exp),
        .out_o    (out_o)
    );

endmodule

//--- rvc_expander.sv
// ------------------------------------------------
// quadrant select and output register, 1 cycle
// illegal compressed words leave as the input word
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_expander
    import rvc_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  rvc_word_t instr_i,
    input  logic      valid_i,
    input  rvc_exp_t  q0_i,
    input  rvc_exp_t  q1_i,
    input  rvc_exp_t  q2_i,
    output rvc_out_t  out_o
);

    rvc_exp_t sel;
    logic     is_comp;
    rvc_out_t out_d;

    // ------------------------------------------------
    // quadrant select
    // ------------------------------------------------
    always_comb begin
        is_comp = 1'b1;
        unique case (instr_i[1:0])
            QUAD_C0: sel = q0_i;
            QUAD_C1: sel = q1_i;
            QUAD_C2: sel = q2_i;
            default: begin
                // full-width word passes straight through
                sel     = '{instr: instr_i, illegal: 1'b0};
                is_comp = 1'b0;
            end
        endcase

        out_d.instr         = sel.illegal ? instr_i : sel.instr;
        out_d.illegal       = sel.illegal;
        out_d.is_compressed = is_comp;
        out_d.valid         = valid_i;
    end

    // ------------------------------------------------
    // output stage
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_o <= '0;
        end else begin
            out_o <= out_d;
        end
    end

endmodule

//--- rvc_q2_dec.sv
// ------------------------------------------------
// combinational expansion of quadrant C2
// FP forms need fp_en_i set
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_q2_dec
    import rvc_pkg::*;
(
    input  logic [15:0] cinstr_i,
    input  logic        fp_en_i,
    output rvc_exp_t    exp_o
);

    logic [4:0] rd;
    logic [4:0] rs2;

    assign rd  = cinstr_i[11:7];
    assign rs2 = cinstr_i[6:2];

    always_comb begin
        exp_o.instr   = '0;
        exp_o.illegal = 1'b0;

        unique case (cinstr_i[15:13])
            C2_SLLI: begin
                exp_o.instr = {6'b000000, cinstr_i[12], rs2, rd, 3'b001, rd, OPCODE_OP_IMM};
            end

            C2_FLDSP: begin
                exp_o.instr = {3'b000, cinstr_i[4:2], cinstr_i[12], cinstr_i[6:5], 3'b000,
                               REG_SP, F3_FLD, rd, OPCODE_LOAD_FP};
                exp_o.illegal = !fp_en_i;
            end

            C2_LWSP, C2_FLWSP: begin
                exp_o.instr = {4'b0000, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                               REG_SP, F3_LW, rd,
                               (cinstr_i[15:13] == C2_FLWSP) ? OPCODE_LOAD_FP : OPCODE_LOAD};
                // integer load to x0 is reserved and FP load needs the enable
                if (cinstr_i[15:13] == C2_FLWSP) begin
                    exp_o.illegal = !fp_en_i;
                end else begin
                    exp_o.illegal = (rd == REG_ZERO);
                end
            end

            C2_JR_MV: begin
                if (!cinstr_i[12]) begin
                    if (rs2 == REG_ZERO) begin
                        // c.jr with rs1 = x0 is reserved
                        exp_o.instr   = {12'h000, rd, 3'b000, REG_ZERO, OPCODE_JALR};
                        exp_o.illegal = (rd == REG_ZERO);
                    end else begin
                        exp_o.instr = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OPCODE_OP};
                    end
                end else if (rs2 != REG_ZERO) begin
                    exp_o.instr = {7'b0000000, rs2, rd, 3'b000, rd, OPCODE_OP};
                end else if (rd == REG_ZERO) begin
                    exp_o.instr = INSTR_EBREAK;
                end else begin
                    // c.jalr links through ra
                    exp_o.instr = {12'h000, rd, 3'b000, REG_RA, OPCODE_JALR};
                end
            end

            C2_FSDSP: begin
                exp_o.instr = {3'b000, cinstr_i[9:7], cinstr_i[12], rs2, REG_SP, F3_FLD,
                               cinstr_i[11:10], 3'b000, OPCODE_STORE_FP};
                exp_o.illegal = !fp_en_i;
            end

            C2_SWSP, C2_FSWSP: begin
                // swsp and fswsp
                exp_o.instr = {4'b0000, cinstr_i[8:7], cinstr_i[12], rs2, REG_SP, F3_LW,
                               cinstr_i[11:9], 2'b00,
                               (cinstr_i[15:13] == C2_FSWSP) ? OPCODE_STORE_FP : OPCODE_STORE};
                exp_o.illegal = (cinstr_i[15:13] == C2_FSWSP) && !fp_en_i;
            end
        endcase
    end

endmodule

//--- rvc_q1_dec.sv
// ------------------------------------------------
// quadrant C1 expansion for RV32 only
// c.subw and c.addw decode as illegal
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_q1_dec
    import rvc_pkg::*;
(
    input  logic [15:0] cinstr_i,
    output rvc_exp_t    exp_o
);

    logic [4:0]  rd;
    logic [4:0]  rd_p;
    logic [4:0]  rs2_p;
    logic [11:0] imm6;
    logic [19:0] jimm;

    assign rd    = cinstr_i[11:7];
    assign rd_p  = {RVC_REG_BASE, cinstr_i[9:7]};
    assign rs2_p = {RVC_REG_BASE, cinstr_i[4:2]};

    // sign-extended 6-bit immediate shared by addi, li and andi
    assign imm6 = {{7{cinstr_i[12]}}, cinstr_i[6:2]};

    // jal offset field in J-type bit order
    assign jimm = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6], cinstr_i[7],
                   cinstr_i[2], cinstr_i[11], cinstr_i[5:3], {9{cinstr_i[12]}}};

    always_comb begin
        exp_o.instr   = '0;
        exp_o.illegal = 1'b0;

        unique case (cinstr_i[15:13])
            C1_ADDI: begin
                // c.nop is the rd = x0 case
                exp_o.instr = {imm6, rd, 3'b000, rd, OPCODE_OP_IMM};
            end

            C1_JAL: begin
                exp_o.instr = {jimm, REG_RA, OPCODE_JAL};
            end

            C1_LI: begin
                exp_o.instr = {imm6, REG_ZERO, 3'b000, rd, OPCODE_OP_IMM};
            end

            C1_LUI: begin
                if (rd == REG_SP) begin
                    // c.addi16sp with the immediate scaled by 16
                    exp_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                                   cinstr_i[6], 4'b0000, REG_SP, 3'b000, REG_SP,
                                   OPCODE_OP_IMM};
                end else begin
                    exp_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, OPCODE_LUI};
                end
                exp_o.illegal = ({cinstr_i[12], cinstr_i[6:2]} == 6'b000000);
            end

            C1_MISC_ALU: begin
                unique case (cinstr_i[11:10])
                    2'b00, 2'b01: begin
                        // srli or srai where bit 10 picks the arithmetic form
                        exp_o.instr = {1'b0, cinstr_i[10], 4'b0000, cinstr_i[12], cinstr_i[6:2],
                                       rd_p, 3'b101, rd_p, OPCODE_OP_IMM};
                    end

                    2'b10: begin
                        exp_o.instr = {imm6, rd_p, 3'b111, rd_p, OPCODE_OP_IMM};
                    end

                    default: begin
                        unique case ({cinstr_i[12], cinstr_i[6:5]})
                            3'b000: exp_o.instr = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p,
                                                   OPCODE_OP};
                            3'b001: exp_o.instr = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p,
                                                   OPCODE_OP};
                            3'b010: exp_o.instr = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p,
                                                   OPCODE_OP};
                            3'b011: exp_o.instr = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p,
                                                   OPCODE_OP};
                            // subw, addw and the two reserved codes
                            default: exp_o.illegal = 1'b1;
                        endcase
                    end
                endcase
            end

            C1_J: begin
                exp_o.instr = {jimm, REG_ZERO, OPCODE_JAL};
            end

            C1_BEQZ, C1_BNEZ: begin
                // bit 13 becomes funct3[0] to pick beq or bne
                exp_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], REG_ZERO, rd_p,
                               2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                               cinstr_i[12], OPCODE_BRANCH};
            end
        endcase
    end

endmodule

//--- rvc_q0_dec.sv
// ------------------------------------------------
// quadrant C0 expansion, combinational
// bits [1:0] are not checked here
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_q0_dec
    import rvc_pkg::*;
(
    input  logic [15:0] cinstr_i,
    input  logic        fp_en_i,
    output rvc_exp_t    exp_o
);

    logic [4:0] rd_p;
    logic [4:0] rs1_p;

    // rd' and rs2' share bits [4:2] in this quadrant
    assign rd_p  = {RVC_REG_BASE, cinstr_i[4:2]};
    assign rs1_p = {RVC_REG_BASE, cinstr_i[9:7]};

    always_comb begin
        exp_o.instr   = '0;
        exp_o.illegal = 1'b0;

        unique case (cinstr_i[15:13])
            C0_ADDI4SPN: begin
                // addi rd', sp, nzuimm
                exp_o.instr = {2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5],
                               cinstr_i[6], 2'b00, REG_SP, 3'b000, rd_p, OPCODE_OP_IMM};
                exp_o.illegal = (cinstr_i[12:5] == 8'h00);
            end

            C0_FLD: begin
                exp_o.instr = {4'b0000, cinstr_i[6:5], cinstr_i[12:10], 3'b000, rs1_p,
                               F3_FLD, rd_p, OPCODE_LOAD_FP};
                exp_o.illegal = !fp_en_i;
            end

            C0_LW, C0_FLW: begin
                // same immediate layout, only the opcode differs
                exp_o.instr = {5'b00000, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                               rs1_p, F3_LW, rd_p,
                               (cinstr_i[15:13] == C0_FLW) ? OPCODE_LOAD_FP : OPCODE_LOAD};
                exp_o.illegal = (cinstr_i[15:13] == C0_FLW) && !fp_en_i;
            end

            C0_FSD: begin
                exp_o.instr = {4'b0000, cinstr_i[6:5], cinstr_i[12], rd_p, rs1_p, F3_FLD,
                               cinstr_i[11:10], 3'b000, OPCODE_STORE_FP};
                exp_o.illegal = !fp_en_i;
            end

            C0_SW, C0_FSW: begin
                exp_o.instr = {5'b00000, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, F3_LW,
                               cinstr_i[11:10], cinstr_i[6], 2'b00,
                               (cinstr_i[15:13] == C0_FSW) ? OPCODE_STORE_FP : OPCODE_STORE};
                exp_o.illegal = (cinstr_i[15:13] == C0_FSW) && !fp_en_i;
            end

            // reserved slot
            default: begin
                exp_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- rvc_cfg_regs.sv
// ------------------------------------------------
// FP-enable bit, cleared by reset
// a write strobe takes effect on the next cycle
// ------------------------------------------------
`timescale 1ns/1ps

module rvc_cfg_regs (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic cfg_we_i,
    input  logic cfg_fp_en_i,
    output logic fp_en_o
);

    // FP loads and stores are illegal until software sets this
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fp_en_o <= 1'b0;
        end else if (cfg_we_i) begin
            fp_en_o <= cfg_fp_en_i;
        end
    end

endmodule

//--- rvc_pkg.sv
// ------------------------------------------------
// shared encodings for the RV32 compressed expander
// RV64-only forms have no constants here
// ------------------------------------------------

package rvc_pkg;

    // ------------------------------------------------
    // major opcodes of the expanded instruction
    // ------------------------------------------------
    localparam logic [6:0] OPCODE_LOAD     = 7'h03;
    localparam logic [6:0] OPCODE_LOAD_FP  = 7'h07;
    localparam logic [6:0] OPCODE_OP_IMM   = 7'h13;
    localparam logic [6:0] OPCODE_STORE    = 7'h23;
    localparam logic [6:0] OPCODE_STORE_FP = 7'h27;
    localparam logic [6:0] OPCODE_OP       = 7'h33;
    localparam logic [6:0] OPCODE_LUI      = 7'h37;
    localparam logic [6:0] OPCODE_BRANCH   = 7'h63;
    localparam logic [6:0] OPCODE_JALR     = 7'h67;
    localparam logic [6:0] OPCODE_JAL      = 7'h6f;

    // quadrant in bits [1:0], 2'b11 marks a full 32-bit word
    localparam logic [1:0] QUAD_C0 = 2'b00;
    localparam logic [1:0] QUAD_C1 = 2'b01;
    localparam logic [1:0] QUAD_C2 = 2'b10;

    // ------------------------------------------------
    // funct3 slots, bits [15:13], RV32 meaning
    // ------------------------------------------------
    // C0, slot 3'b100 is reserved
    localparam logic [2:0] C0_ADDI4SPN = 3'b000;
    localparam logic [2:0] C0_FLD      = 3'b001;
    localparam logic [2:0] C0_LW       = 3'b010;
    localparam logic [2:0] C0_FLW      = 3'b011;
    localparam logic [2:0] C0_FSD      = 3'b101;
    localparam logic [2:0] C0_SW       = 3'b110;
    localparam logic [2:0] C0_FSW      = 3'b111;

    localparam logic [2:0] C1_ADDI     = 3'b000;
    localparam logic [2:0] C1_JAL      = 3'b001;
    localparam logic [2:0] C1_LI       = 3'b010;
    localparam logic [2:0] C1_LUI      = 3'b011;
    localparam logic [2:0] C1_MISC_ALU = 3'b100;
    localparam logic [2:0] C1_J        = 3'b101;
    localparam logic [2:0] C1_BEQZ     = 3'b110;
    localparam logic [2:0] C1_BNEZ     = 3'b111;

    localparam logic [2:0] C2_SLLI     = 3'b000;
    localparam logic [2:0] C2_FLDSP    = 3'b001;
    localparam logic [2:0] C2_LWSP     = 3'b010;
    localparam logic [2:0] C2_FLWSP    = 3'b011;
    localparam logic [2:0] C2_JR_MV    = 3'b100;
    localparam logic [2:0] C2_FSDSP    = 3'b101;
    localparam logic [2:0] C2_SWSP     = 3'b110;
    localparam logic [2:0] C2_FSWSP    = 3'b111;

    // load/store width in the expanded word
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_FLD = 3'b011;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // prefix that maps rd'/rs1'/rs2' onto x8..x15
    localparam logic [1:0] RVC_REG_BASE = 2'b01;

    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    // ------------------------------------------------
    // types
    // ------------------------------------------------
    typedef logic [31:0] rvc_word_t;

    // result of one quadrant decoder
    typedef struct packed {
        rvc_word_t instr;
        logic      illegal;
    } rvc_exp_t;

    // registered output bundle
    typedef struct packed {
        rvc_word_t instr;
        logic      illegal;
        logic      is_compressed;
        logic      valid;
    } rvc_out_t;

endpackage
